// File: logic/cpu_pkg.sv
// Execution core package: data and register types, opcode and ALU-op encodings, field positions
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] data_t;
    typedef logic [3:0]  reg_addr_t;

    // Instruction class in bits 31 to 28
    typedef enum logic [3:0] {
        op_nop       = 4'b0000,
        op_alu_reg   = 4'b0001,
        op_alu_const = 4'b0010
    } opcode_t;

    // ALU function in bits 27 to 24
    // Load and load-high share the 110x pattern
    typedef enum logic [3:0] {
        alu_or      = 4'b0000,
        alu_and     = 4'b0001,
        alu_xor     = 4'b0010,
        alu_add     = 4'b0011,
        alu_sub     = 4'b0100,
        alu_shiftl  = 4'b0101,
        alu_shiftr  = 4'b0110,
        alu_not     = 4'b0111,
        alu_load    = 4'b1100,
        alu_loadhi  = 4'b1101
    } alu_op_t;

    // Instruction field positions
    localparam int opcode_lsb = 28;
    localparam int alu_op_lsb = 24;
    localparam int const_msb  = 23;
    localparam int const_lsb  = 8;

    // Breg overlaps the low nibble of the constant
    localparam int breg_lsb   = 8;
    localparam int areg_lsb   = 4;
    localparam int dreg_lsb   = 0;

    // Size of the register bank
    localparam int num_regs   = 16;

endpackage

`default_nettype wire

// File: logic/operand_if.sv
// Decoded operand bundle passed from the decode stage to the execute stage
`default_nettype none

interface operand_if;
    import cpu_pkg::*;

    logic      valid;
    alu_op_t   alu_op;
    // Source numbers kept for the forwarding compare
    reg_addr_t areg;
    reg_addr_t breg;
    reg_addr_t dreg;
    data_t     data_a;
    data_t     data_b;
    // Constant already extended to a full word
    data_t     const_val;
    logic      use_const;

    modport decode (
        output valid, alu_op, areg, breg, dreg, data_a, data_b, const_val, use_const
    );

    modport execute (
        input valid, alu_op, areg, breg, dreg, data_a, data_b, const_val, use_const
    );

endinterface

`default_nettype wire

// File: logic/result_if.sv
// Result register contents shared by write-back, forwarding and the core outputs
`default_nettype none

interface result_if;
    import cpu_pkg::*;

    logic      valid;
    reg_addr_t dreg;
    data_t     data;

    // Driven by the execute stage result register
    modport source (
        output valid, dreg, data
    );

    // Register bank write port
    modport sink (
        input valid, dreg, data
    );

endinterface

`default_nettype wire

// File: logic/instr_decode.sv
// Decode stage: splits the instruction, extends the constant and registers the operands
`default_nettype none

module instr_decode (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire cpu_pkg::data_t    instr,
    input  wire logic              instr_valid,
    output cpu_pkg::reg_addr_t     rd_addr_a,
    output cpu_pkg::reg_addr_t     rd_addr_b,
    input  wire cpu_pkg::data_t    rd_data_a,
    input  wire cpu_pkg::data_t    rd_data_b,
    operand_if.decode              opnd
);
    import cpu_pkg::*;

    logic [3:0]     opcode_bits;
    alu_op_t        alu_op;
    logic [15:0]    const16;
    reg_addr_t      dreg;
    logic           is_alu;
    logic           zero_ext;
    data_t          const_ext;

    // Field extraction
    assign opcode_bits = instr[opcode_lsb +: 4];
    assign alu_op      = alu_op_t'(instr[alu_op_lsb +: 4]);
    assign const16     = instr[const_msb:const_lsb];
    assign dreg        = instr[dreg_lsb +: 4];

    // Bank read happens on the same edge that loads the decode register
    assign rd_addr_a   = instr[areg_lsb +: 4];
    assign rd_addr_b   = instr[breg_lsb +: 4];

    // Unknown opcodes behave like nop
    assign is_alu = (opcode_bits == op_alu_reg) || (opcode_bits == op_alu_const);

    // Load and load-high take the constant unsigned
    assign zero_ext  = (alu_op == alu_load) || (alu_op == alu_loadhi);
    assign const_ext = zero_ext ? {16'h0000, const16} : {{16{const16[15]}}, const16};

    // Only a known ALU op aimed at a real register produces a result
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            opnd.valid <= 1'b0;
        end
        else
        begin
            opnd.valid <= instr_valid && is_alu && (dreg != '0);
        end
    end

    // Payload fields, meaningful only while valid is high
    always_ff @(posedge clk)
    begin
        opnd.alu_op    <= alu_op;
        opnd.areg      <= rd_addr_a;
        opnd.breg      <= rd_addr_b;
        opnd.dreg      <= dreg;
        opnd.const_val <= const_ext;
        opnd.use_const <= (opcode_bits == op_alu_const);
    end

    // Register values arrive already clocked by the bank
    assign opnd.data_a = rd_data_a;
    assign opnd.data_b = rd_data_b;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
// Sixteen-word register bank with write-first reads and register zero tied to zero
`default_nettype none

module reg_file (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire cpu_pkg::reg_addr_t rd_addr_a,
    input  wire cpu_pkg::reg_addr_t rd_addr_b,
    output cpu_pkg::data_t          rd_data_a,
    output cpu_pkg::data_t          rd_data_b,
    result_if.sink                  wr
);
    import cpu_pkg::*;

    data_t regs [num_regs];

    // Read value with bypass of the write in this cycle
    function automatic data_t read_word(input reg_addr_t addr);
        data_t word;
        if (addr == '0)
            word = '0;
        else if (wr.valid && (wr.dreg == addr))
            word = wr.data;
        else
            word = regs[addr];
        return word;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
            rd_data_a <= '0;
            rd_data_b <= '0;
        end
        else
        begin
            // Writes to register zero are dropped
            if (wr.valid && (wr.dreg != '0))
            begin
                regs[wr.dreg] <= wr.data;
            end
            rd_data_a <= read_word(rd_addr_a);
            rd_data_b <= read_word(rd_addr_b);
        end
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
// Combinational ALU for logic, arithmetic, shift and load operations
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t op,
    input  wire cpu_pkg::data_t   a,
    input  wire cpu_pkg::data_t   b,
    output cpu_pkg::data_t        y
);
    import cpu_pkg::*;

    always_comb
    begin
        case (op)
            alu_or:
            begin
                y = a | b;
            end
            alu_and:
            begin
                y = a & b;
            end
            alu_xor:
            begin
                y = a ^ b;
            end
            alu_add:
            begin
                y = a + b;
            end
            alu_sub:
            begin
                y = a - b;
            end
            // Shift amount from the low five bits of b
            alu_shiftl:
            begin
                y = a << b[4:0];
            end
            alu_shiftr:
            begin
                y = a >> b[4:0];
            end
            alu_not:
            begin
                y = ~a;
            end
            alu_load:
            begin
                y = b;
            end
            // Upper half from b, lower half of a kept
            alu_loadhi:
            begin
                y = {b[15:0], a[15:0]};
            end
            default:
            begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
// Execute stage: operand forwarding, ALU and the result register
`default_nettype none

module execute_stage (
    input  wire logic   clk,
    input  wire logic   reset,
    operand_if.execute  opnd,
    result_if.source    res
);
    import cpu_pkg::*;

    logic   fwd_a;
    logic   fwd_b;
    data_t  op_a;
    data_t  op_b;
    data_t  alu_y;

    // Forward when the instruction just ahead writes a source register
    // Register zero never matches since decode drops dreg zero
    assign fwd_a = res.valid && (res.dreg == opnd.areg);
    assign fwd_b = res.valid && (res.dreg == opnd.breg);

    assign op_a = fwd_a ? res.data : opnd.data_a;

    // Constant takes priority over the b register
    always_comb
    begin
        if (opnd.use_const)
        begin
            op_b = opnd.const_val;
        end
        else if (fwd_b)
        begin
            op_b = res.data;
        end
        else
        begin
            op_b = opnd.data_b;
        end
    end

    alu i_alu (
        .op (opnd.alu_op),
        .a  (op_a),
        .b  (op_b),
        .y  (alu_y)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            res.valid <= 1'b0;
        end
        else
        begin
            res.valid <= opnd.valid;
        end
    end

    // Result payload
    always_ff @(posedge clk)
    begin
        res.dreg <= opnd.dreg;
        res.data <= alu_y;
    end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
// Three-stage integer execution core: decode, execute and register write-back
`default_nettype none

module cpu_core (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire cpu_pkg::data_t    instr,
    input  wire logic              instr_valid,
    output logic                   result_valid,
    output cpu_pkg::reg_addr_t     result_reg,
    output cpu_pkg::data_t         result_data
);
    import cpu_pkg::*;

    reg_addr_t  rd_addr_a;
    reg_addr_t  rd_addr_b;
    data_t      rd_data_a;
    data_t      rd_data_b;

    operand_if opnd_bus ();
    result_if  res_bus ();

    instr_decode i_instr_decode (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .opnd        (opnd_bus.decode)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr        (res_bus.sink)
    );

    execute_stage i_execute_stage (
        .clk   (clk),
        .reset (reset),
        .opnd  (opnd_bus.execute),
        .res   (res_bus.source)
    );

    // Every bank write is visible on the result ports
    assign result_valid = res_bus.valid;
    assign result_reg   = res_bus.dreg;
    assign result_data  = res_bus.data;

endmodule

`default_nettype wire

// File: bench/cpu_core_checker.sv
// Result port assertions for the execution core, bound into cpu_core
`default_nettype none

module cpu_core_checker (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               instr_valid,
    input wire logic               result_valid,
    input wire cpu_pkg::reg_addr_t result_reg
);
    timeunit 1ns;
    timeprecision 1ps;

    // Assertion failures seen so far
    int failures = 0;

    // Result register comes out of reset empty
    result_idle_after_reset: assert property (@(posedge clk) reset |=> !result_valid)
    else
    begin
        $error("result_valid high in the cycle after reset");
        failures++;
    end

    // Decode never lets a write to register zero through
    result_reg_nonzero: assert property (
        @(posedge clk) disable iff (reset) result_valid |-> (result_reg != '0))
    else
    begin
        $error("result_valid high with result_reg zero");
        failures++;
    end

    // Two stages of latency from instruction to result
    bubble_gives_no_result: assert property (
        @(posedge clk) disable iff (reset) !instr_valid |-> ##2 !result_valid)
    else
    begin
        $error("result_valid high two cycles after an invalid instruction cycle");
        failures++;
    end

endmodule

bind cpu_core cpu_core_checker i_cpu_core_checker (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .result_reg   (result_reg)
);

`default_nettype wire

// File: bench/cpu_core_tb.sv
// Testbench for the execution core driving a table of instructions and checking each result
`default_nettype none

module cpu_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int num_rows   = 33;
    localparam int clk_period = 100;

    logic       clk = 1'b0;
    logic       reset;
    data_t      instr;
    logic       instr_valid;
    logic       result_valid;
    reg_addr_t  result_reg;
    data_t      result_data;

    // Stimulus and expected results, one row per instruction slot
    string      row_name  [num_rows];
    data_t      row_instr [num_rows];
    logic       row_valid [num_rows];
    logic       exp_valid [num_rows];
    reg_addr_t  exp_reg   [num_rows];
    data_t      exp_data  [num_rows];
    int         row_count = 0;

    cpu_core i_cpu_core (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result_valid (result_valid),
        .result_reg   (result_reg),
        .result_data  (result_data)
    );

    always
    begin
        #(clk_period / 2) clk = ~clk;
    end

    // Instruction word from its fields
    function automatic data_t encode(input logic [3:0] opc, input alu_op_t op,
                                     input logic [15:0] k, input reg_addr_t a,
                                     input reg_addr_t d);
        data_t w;
        w = '0;
        w[opcode_lsb +: 4]     = opc;
        w[alu_op_lsb +: 4]     = op;
        w[const_msb:const_lsb] = k;
        w[areg_lsb +: 4]       = a;
        w[dreg_lsb +: 4]       = d;
        return w;
    endfunction

    function automatic data_t reg_word(input alu_op_t op, input reg_addr_t d,
                                       input reg_addr_t a, input reg_addr_t b);
        data_t w;
        w = encode(op_alu_reg, op, 16'h0000, a, d);
        w[breg_lsb +: 4] = b;
        return w;
    endfunction

    function automatic data_t const_word(input alu_op_t op, input reg_addr_t d,
                                         input reg_addr_t a, input logic [15:0] k);
        return encode(op_alu_const, op, k, a, d);
    endfunction

    task automatic add_row(input string name, input data_t word, input logic valid,
                           input logic rvalid, input reg_addr_t rreg, input data_t rdata);
        if (row_count < num_rows)
        begin
            row_name[row_count]  = name;
            row_instr[row_count] = word;
            row_valid[row_count] = valid;
            exp_valid[row_count] = rvalid;
            exp_reg[row_count]   = rreg;
            exp_data[row_count]  = rdata;
        end
        row_count++;
    endtask

    task automatic build_table();
        // Constant loads, zero-extended for load and load-high
        add_row("load r1", const_word(alu_load, 1, 0, 16'h1234), 1, 1, 1, 32'h0000_1234);
        add_row("loadhi r1", const_word(alu_loadhi, 1, 1, 16'hABCD), 1, 1, 1, 32'hABCD_1234);
        add_row("load r2", const_word(alu_load, 2, 0, 16'h8001), 1, 1, 2, 32'h0000_8001);
        add_row("add minus one", const_word(alu_add, 3, 2, 16'hFFFF), 1, 1, 3, 32'h0000_8000);
        add_row("load r4", const_word(alu_load, 4, 0, 16'h00F0), 1, 1, 4, 32'h0000_00F0);
        add_row("loadhi r4", const_word(alu_loadhi, 4, 4, 16'h0F0F), 1, 1, 4, 32'h0F0F_00F0);
        add_row("invalid cycle", reg_word(alu_add, 5, 1, 2), 0, 0, 0, 32'h0);
        add_row("nop", encode(op_nop, alu_add, 16'h0000, 1, 5), 1, 0, 0, 32'h0);
        // Register-register operations
        add_row("or", reg_word(alu_or, 5, 1, 4), 1, 1, 5, 32'hAFCF_12F4);
        add_row("and", reg_word(alu_and, 6, 1, 4), 1, 1, 6, 32'h0B0D_0030);
        add_row("xor", reg_word(alu_xor, 7, 1, 4), 1, 1, 7, 32'hA4C2_12C4);
        add_row("add", reg_word(alu_add, 8, 1, 2), 1, 1, 8, 32'hABCD_9235);
        add_row("sub", reg_word(alu_sub, 9, 2, 1), 1, 1, 9, 32'h5433_6DCD);
        add_row("shiftl", reg_word(alu_shiftl, 10, 4, 2), 1, 1, 10, 32'h1E1E_01E0);
        add_row("shiftr", reg_word(alu_shiftr, 11, 1, 2), 1, 1, 11, 32'h55E6_891A);
        add_row("not", reg_word(alu_not, 12, 4, 0), 1, 1, 12, 32'hF0F0_FF0F);
        add_row("shiftr const", const_word(alu_shiftr, 13, 1, 16'h0004), 1, 1, 13, 32'h0ABC_D123);
        // Back-to-back dependencies
        add_row("add const", const_word(alu_add, 14, 2, 16'h0010), 1, 1, 14, 32'h0000_8011);
        add_row("fwd a", reg_word(alu_sub, 15, 14, 2), 1, 1, 15, 32'h0000_0010);
        add_row("fwd b", reg_word(alu_add, 5, 3, 15), 1, 1, 5, 32'h0000_8010);
        add_row("fwd a and b", reg_word(alu_add, 6, 5, 5), 1, 1, 6, 32'h0001_0020);
        // Two apart and across bubbles
        add_row("load r7", const_word(alu_load, 7, 0, 16'h0100), 1, 1, 7, 32'h0000_0100);
        add_row("load r8", const_word(alu_load, 8, 0, 16'h0003), 1, 1, 8, 32'h0000_0003);
        add_row("two apart", reg_word(alu_shiftl, 9, 7, 8), 1, 1, 9, 32'h0000_0800);
        add_row("bubble", reg_word(alu_add, 10, 9, 8), 0, 0, 0, 32'h0);
        add_row("after bubble", reg_word(alu_add, 10, 9, 8), 1, 1, 10, 32'h0000_0803);
        add_row("bubble", reg_word(alu_add, 10, 9, 8), 0, 0, 0, 32'h0);
        add_row("bubble", reg_word(alu_add, 10, 9, 8), 0, 0, 0, 32'h0);
        add_row("three apart", reg_word(alu_sub, 11, 10, 9), 1, 1, 11, 32'h0000_0003);
        // Register zero and unknown opcodes
        add_row("write r0", reg_word(alu_add, 0, 1, 2), 1, 0, 0, 32'h0);
        add_row("unknown opcode", encode(4'hF, alu_add, 16'h0001, 1, 3), 1, 0, 0, 32'h0);
        add_row("read r0 reg", reg_word(alu_or, 2, 0, 0), 1, 1, 2, 32'h0000_0000);
        add_row("read r0 const", const_word(alu_add, 3, 0, 16'h0005), 1, 1, 3, 32'h0000_0005);
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (expected !== actual)
        begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    initial
    begin
        int k;
        reset = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        build_table();
        if (row_count != num_rows)
        begin
            $display("error: stimulus table holds %0d rows instead of %0d", row_count, num_rows);
            $display("Result: FAILED");
            $fatal(1, "table size mismatch");
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // Row j goes in at this edge, row j-2 is on the result ports after it
        for (int j = 0; j < num_rows + 2; j++)
        begin
            @(posedge clk);
            if (j < num_rows)
            begin
                instr       <= row_instr[j];
                instr_valid <= row_valid[j];
            end
            else
            begin
                instr       <= '0;
                instr_valid <= 1'b0;
            end
            @(negedge clk);
            if (j < 2)
            begin
                check_value("idle after reset valid", 32'h0, data_t'(result_valid));
            end
            else
            begin
                k = j - 2;
                check_value({row_name[k], " valid"}, data_t'(exp_valid[k]),
                            data_t'(result_valid));
                if (exp_valid[k])
                begin
                    check_value({row_name[k], " reg"}, data_t'(exp_reg[k]), data_t'(result_reg));
                    check_value({row_name[k], " data"}, exp_data[k], result_data);
                end
            end
        end
        if (i_cpu_core.i_cpu_core_checker.failures == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #((num_rows + 10) * clk_period);
        $display("error: watchdog expired before the instruction stream finished");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/cpu_pkg.sv
logic/operand_if.sv
logic/result_if.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/execute_stage.sv
logic/cpu_core.sv
bench/cpu_core_checker.sv
bench/cpu_core_tb.sv
